// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= stoch_integ_tb
FILELIST  ?= stoch_integ.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

$(BIN): $(FILELIST) $(wildcard design/*.sv include/*.svh test/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TESTBENCH FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/lfsr_rand_source.sv ====
// Runs the 31-bit LFSR and cuts its state into the random words used by all comparators
`timescale 1ns/10ps
`include "stoch_integ_defs.svh"

module lfsr_rand_source
    import stoch_integ_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,      // Async, active high
    output rand_words_t rand_words  // Slices of the current state
);

    localparam int unsigned TOP = `STOCH_LFSR_W - 1;

    lfsr_t state_q;  // Fibonacci register
    logic  fb;       // New bit 0

    assign fb = state_q[`STOCH_LFSR_TAP] ^ state_q[TOP];

    // Shift up one place per cycle
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            state_q <= lfsr_t'(`STOCH_LFSR_SEED);
        end else begin
            state_q <= {state_q[TOP-1:0], fb};
        end
    end

    // Distinct bit mixes keep the streams roughly decorrelated
    // Comparators that see the same word would produce correlated bits
    always_comb begin
        rand_words.in_a    = state_q[8:0];
        rand_words.in_b    = {state_q[5:0], state_q[18:16]};
        rand_words.stage_a = state_q[30:22];
        rand_words.stage_b = {state_q[15:13], state_q[6:1]};
        rand_words.stage_c = {state_q[24:19], state_q[14:12]};  // Also feeds stream_c
    end

    // Only the slices leave this block
    // Nothing downstream depends on the bit layout of the register

endmodule

// ==== design/serial_value_rx.sv ====
// Receives the two framed serial inputs and presents them as a pair of held 9-bit values
`timescale 1ns/10ps
`include "stoch_integ_defs.svh"

module serial_value_rx
    import stoch_integ_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,     // Async, active high
    input  logic        serial_a,  // One data bit per cycle
    input  logic        serial_b,
    output input_pair_t values     // Updated once per frame
);

    localparam int unsigned SLOT_W = $clog2(`STOCH_FRAME_SLOTS);
    localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(`STOCH_FRAME_SLOTS - 1);

    logic [SLOT_W-1:0] slot_q;   // Free-running frame position
    input_pair_t       shift_q;  // Bits gathered so far

    // Frame position, wraps after the dummy slot
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            slot_q <= '0;
        end else if (slot_q == LAST_SLOT) begin
            slot_q <= '0;
        end else begin
            slot_q <= slot_q + 1'b1;
        end
    end

    // LSB arrives first, so bits enter at the top and walk down
    always_ff @(posedge clk) begin
        if (slot_q != LAST_SLOT) begin
            shift_q.a <= {serial_a, shift_q.a[`STOCH_VALUE_W-1:1]};
            shift_q.b <= {serial_b, shift_q.b[`STOCH_VALUE_W-1:1]};
        end
    end

    // Dummy slot ends the frame
    // All nine bits sit in place, so publish them for the next ten cycles
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            values <= '0;
        end else if (slot_q == LAST_SLOT) begin
            values <= shift_q;  // Input bit of slot 9 is ignored
        end
    end

endmodule

// ==== design/snapshot_serial_tx.sv ====
// Captures the stage counts periodically and sends each as a 10-slot serial frame
`timescale 1ns/10ps
`include "stoch_integ_defs.svh"

module snapshot_serial_tx
    import stoch_integ_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,      // Async, active high
    input  stage_values_t counts,     // Live integrator counts
    output stage_bits_t   serial_out  // One framed line per stage
);

    localparam int unsigned IVL_W  = $clog2(`STOCH_SNAP_INTERVAL);
    localparam int unsigned SLOT_W = $clog2(`STOCH_FRAME_SLOTS);
    localparam logic [IVL_W-1:0]  LAST_IVL  = IVL_W'(`STOCH_SNAP_INTERVAL - 1);
    localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(`STOCH_FRAME_SLOTS - 1);

    logic [IVL_W-1:0]  ivl_q;    // Snapshot interval position
    logic [SLOT_W-1:0] slot_q;   // Frame position, shared by all three lines
    stage_values_t     snap_q;   // Counts at the last interval boundary
    stage_values_t     shift_q;  // Bits still to send in the current frame

    // Interval counter and capture, capture on the edge where it reads 0
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            ivl_q  <= '0;
            snap_q <= '0;  // First frames go out as zero
        end else begin
            ivl_q <= (ivl_q == LAST_IVL) ? '0 : ivl_q + 1'b1;
            if (ivl_q == '0) begin
                snap_q <= counts;
            end
        end
    end

    // Slot counter, independent of the interval
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            slot_q <= '0;
        end else begin
            slot_q <= (slot_q == LAST_SLOT) ? '0 : slot_q + 1'b1;
        end
    end

    // Framers, each bit shows up one cycle after its slot
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            serial_out <= '0;
        end else if (slot_q == '0) begin
            serial_out <= {snap_q.a[0], snap_q.b[0], snap_q.c[0]};  // Bit 0 straight out
        end else if (slot_q == LAST_SLOT) begin
            serial_out <= '0;  // Dummy slot
        end else begin
            serial_out <= {shift_q.a[0], shift_q.b[0], shift_q.c[0]};
        end
    end

    // Payload shifter, reloaded in slot 0 before any of it is used
    always_ff @(posedge clk) begin
        if (slot_q == '0) begin
            shift_q.a <= snap_q.a >> 1;  // Bit 1 waits at the bottom
            shift_q.b <= snap_q.b >> 1;
            shift_q.c <= snap_q.c >> 1;
        end else begin
            shift_q.a <= shift_q.a >> 1;
            shift_q.b <= shift_q.b >> 1;
            shift_q.c <= shift_q.c >> 1;
        end
    end

endmodule

// ==== design/stoch_integ_pkg.sv ====
// Value, LFSR and grouping types shared by the integrator RTL and its testbench
`include "stoch_integ_defs.svh"

package stoch_integ_pkg;

    // Unsigned probability, value over 512 is P(1)
    typedef logic [`STOCH_VALUE_W-1:0] value_t;

    typedef logic [`STOCH_LFSR_W-1:0] lfsr_t;  // Full LFSR state

    // Decoded serial inputs
    typedef struct packed {
        value_t a;  // Drives stage a up
        value_t b;  // Drives every stage down
    } input_pair_t;

    // Integrator counts, one per stage
    typedef struct packed {
        value_t a;  // ~ t
        value_t b;  // ~ t^2/2
        value_t c;  // ~ t^3/6
    } stage_values_t;

    // One serial line per stage
    typedef struct packed {
        logic a;
        logic b;
        logic c;
    } stage_bits_t;

    // Random words, one per comparator
    typedef struct packed {
        value_t in_a;
        value_t in_b;
        value_t stage_a;
        value_t stage_b;
        value_t stage_c;
    } rand_words_t;

endpackage

// ==== design/stoch_integ_stage.sv ====
// One integrator stage: saturating up/down counter whose count is re-encoded as a bitstream
`timescale 1ns/10ps
`include "stoch_integ_defs.svh"

module stoch_integ_stage
    import stoch_integ_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,      // Async, active high
    input  logic   inc_bit,    // Stochastic up stream
    input  logic   dec_bit,    // Stochastic down stream
    input  value_t rand_word,  // Random word for the output comparator
    output value_t count,      // Integrated value
    output logic   sn_bit      // count/512 probability stream
);

    localparam value_t MAX_COUNT = value_t'(`STOCH_VALUE_MAX);

    logic step_up;  // Net +1 request
    logic step_dn;  // Net -1 request

    // Equal strobes cancel
    assign step_up = inc_bit & ~dec_bit;
    assign step_dn = dec_bit & ~inc_bit;

    // Counter integrates the difference of the two streams
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            count <= '0;
        end else if (step_up && count != MAX_COUNT) begin
            count <= count + 1'b1;  // Hold at the top
        end else if (step_dn && count != '0) begin
            count <= count - 1'b1;  // Hold at zero
        end
    end

    // Back to a stream, same cycle as the count
    // Strict compare, so a zero count never gives a one
    assign sn_bit = (count > rand_word);

endmodule

// ==== design/stoch_integ_top.sv ====
// Top of the stochastic integrator chain; connects receiver, random source, stages and transmitter
`timescale 1ns/10ps

module stoch_integ_top
    import stoch_integ_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,       // Async, active high
    input  logic        serial_a,    // Framed input A
    input  logic        serial_b,    // Framed input B
    output stage_bits_t serial_out,  // Framed stage counts
    output logic        stream_c     // Live stage c bitstream
);

    input_pair_t   values;      // Held input probabilities
    rand_words_t   rand_words;  // Per-comparator random words
    stage_values_t counts;      // Gathered for the transmitter
    logic          in_a_bit;    // Input A stream
    logic          in_b_bit;    // Input B stream, common decrement
    logic          sn_a;
    logic          sn_b;
    logic          sn_c;

    serial_value_rx serial_value_rx_i (
        .clk(clk), .rst_n(rst_n), .serial_a(serial_a), .serial_b(serial_b), .values(values)
    );

    lfsr_rand_source lfsr_rand_source_i (.clk(clk), .rst_n(rst_n), .rand_words(rand_words));

    // Input comparators
    assign in_a_bit = (values.a > rand_words.in_a);
    assign in_b_bit = (values.b > rand_words.in_b);

    // Chain: A -> stage a -> stage b -> stage c, B pulls every stage down
    // With B at zero the counts follow t, t^2/2, t^3/6
    stoch_integ_stage stage_a_i (
        .clk(clk), .rst_n(rst_n), .inc_bit(in_a_bit), .dec_bit(in_b_bit),
        .rand_word(rand_words.stage_a), .count(counts.a), .sn_bit(sn_a)
    );
    stoch_integ_stage stage_b_i (
        .clk(clk), .rst_n(rst_n), .inc_bit(sn_a), .dec_bit(in_b_bit),
        .rand_word(rand_words.stage_b), .count(counts.b), .sn_bit(sn_b)
    );
    stoch_integ_stage stage_c_i (
        .clk(clk), .rst_n(rst_n), .inc_bit(sn_b), .dec_bit(in_b_bit),
        .rand_word(rand_words.stage_c), .count(counts.c), .sn_bit(sn_c)
    );

    snapshot_serial_tx snapshot_serial_tx_i (
        .clk(clk), .rst_n(rst_n), .counts(counts), .serial_out(serial_out)
    );

    assign stream_c = sn_c;  // Zero in reset since the count is zero

endmodule

// ==== include/stoch_integ_defs.svh ====
// Widths, LFSR and timing constants for the integrator chain; include wherever they are used
`ifndef STOCH_INTEG_DEFS_SVH
`define STOCH_INTEG_DEFS_SVH

// Probability values and counters, value/512 is the chance of a one
`define STOCH_VALUE_W 9
// Saturation ceiling of every counter
`define STOCH_VALUE_MAX 511

// Fibonacci LFSR length and start state
`define STOCH_LFSR_W 31
`define STOCH_LFSR_SEED 134995
// Feedback tap, XORed with the top bit
`define STOCH_LFSR_TAP 27

// Serial frame, nine data slots LSB first then one zero dummy slot
`define STOCH_FRAME_SLOTS 10

// Cycles between captures of the stage counts
`define STOCH_SNAP_INTERVAL 16

`endif

// ==== stoch_integ.f ====
+incdir+include
design/stoch_integ_pkg.sv
design/serial_value_rx.sv
design/lfsr_rand_source.sv
design/stoch_integ_stage.sv
design/snapshot_serial_tx.sv
design/stoch_integ_top.sv
test/stoch_integ_assert.sv
test/stoch_integ_tb.sv

// ==== test/stoch_integ_assert.sv ====
// Concurrent checks on framing and reset behaviour at the top-level ports, bound into the DUT
`timescale 1ns/10ps
`include "stoch_integ_defs.svh"

module stoch_integ_assert
    import stoch_integ_pkg::*;
(
    input logic        clk,
    input logic        rst_n,       // Async, active high
    input stage_bits_t serial_out,
    input logic        stream_c
);

    localparam logic [3:0] LAST_SLOT = 4'(`STOCH_FRAME_SLOTS - 1);

    logic [3:0] slot_q;    // Follows the transmitter slot counter
    int         failures = 0;  // Assertion failures so far

    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            slot_q <= '0;
        end else begin
            slot_q <= (slot_q == LAST_SLOT) ? '0 : slot_q + 1'b1;
        end
    end

    // Dummy slot goes out as zero on every line
    dummy_slot_zero: assert property (@(posedge clk) disable iff (rst_n)
        (slot_q == LAST_SLOT) |=> (serial_out == '0))
        else begin
            $error("serial_out not zero in the dummy slot");
            failures++;
        end

    known_outputs: assert property (@(posedge clk) !rst_n |-> !$isunknown({serial_out, stream_c}))
        else begin
            $error("serial_out or stream_c unknown");
            failures++;
        end

    reset_stream_zero: assert property (@(posedge clk) rst_n |-> !stream_c)
        else begin
            $error("stream_c high during reset");
            failures++;
        end

endmodule

// ==== test/stoch_integ_tb.sv ====
// Self-checking testbench for the integrator chain; framed LCG stimulus against a cycle model
`timescale 1ns/10ps
`include "stoch_integ_defs.svh"

module stoch_integ_tb import stoch_integ_pkg::*; ();

    localparam int PERIOD = 20;
    localparam int SETTLE = 64;  // New inputs reach the frames well within this
    localparam int TOTAL_CYCLES = 3 + 9 * (SETTLE + 1) + 200 + 2 * 800 + 2 * 4000 + 4 * 200;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        serial_a = 1'b0;
    logic        serial_b = 1'b0;
    stage_bits_t serial_out;
    logic        stream_c;

    logic [31:0]   lcg_state = 32'h5864bbac;
    value_t        next_a = '0;   // Values for the next frame
    value_t        next_b = '0;
    value_t        frame_a = '0;  // Values being sent now
    value_t        frame_b = '0;
    int            errors = 0;
    int            frames = 0;
    int            tests_passed = 0;
    int            tests_failed = 0;
    int            mode = 0;      // 1 rising, 2 full, 3 empty, 0 no trend check
    logic          have_last = 1'b0;
    stage_values_t dec;           // Frame being decoded
    stage_values_t last_dec;

    // Reference model state
    lfsr_t         m_lfsr;
    int            m_rx_slot;
    value_t        m_rx_a;
    value_t        m_rx_b;
    input_pair_t   m_val;
    stage_values_t m_cnt;
    int            m_ivl;
    int            m_tx_slot;
    stage_values_t m_snap;
    stage_values_t m_frame;   // Snapshot taken at slot 0
    stage_bits_t   m_out;
    int            m_out_idx; // Slot the current output bit belongs to

    always #(PERIOD / 2) clk = ~clk;

    stoch_integ_top stoch_integ_top_i (
        .clk(clk), .rst_n(rst_n), .serial_a(serial_a), .serial_b(serial_b),
        .serial_out(serial_out), .stream_c(stream_c)
    );

    bind stoch_integ_top stoch_integ_assert stoch_integ_assert_i (
        .clk(clk), .rst_n(rst_n), .serial_out(serial_out), .stream_c(stream_c)
    );

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic value_t random_value();
        return value_t'(next_random() >> 23);  // Top bits are the most random
    endfunction

    function automatic value_t step_count(input value_t c, input logic up, input logic dn);
        if (up && !dn && c != 9'd511) return c + 1'b1;
        if (dn && !up && c != 9'd0) return c - 1'b1;
        return c;
    endfunction

    task automatic note_mismatch(input string msg);
        errors++;
        $display("FAILED at %0t ns: %s", $time, msg);
    endtask

    // One clock of the model, then drive the bit for the new receiver slot
    always @(posedge clk) begin : model_step
        logic        ia, ib, sa, sb;
        logic [31:0] junk;
        if (rst_n) begin
            m_lfsr = lfsr_t'(`STOCH_LFSR_SEED);
            m_rx_slot = 0;
            m_val = '0;
            m_cnt = '0;
            m_ivl = 0;
            m_tx_slot = 0;
            m_snap = '0;
            m_out = '0;
            m_out_idx = 9;  // Nothing to decode in reset
        end else begin
            ia = m_val.a > m_lfsr[8:0];
            ib = m_val.b > {m_lfsr[5:0], m_lfsr[18:16]};
            sa = m_cnt.a > m_lfsr[30:22];
            sb = m_cnt.b > {m_lfsr[15:13], m_lfsr[6:1]};
            m_out_idx = m_tx_slot;
            if (m_tx_slot == 0) begin
                m_frame = m_snap;  // Old snapshot, before this edge's capture
                m_out = {m_snap.a[0], m_snap.b[0], m_snap.c[0]};
            end else if (m_tx_slot == 9) begin
                m_out = '0;
            end else begin
                m_out = {m_frame.a[m_tx_slot], m_frame.b[m_tx_slot], m_frame.c[m_tx_slot]};
            end
            if (m_ivl == 0) m_snap = m_cnt;
            m_ivl = (m_ivl + 1) % `STOCH_SNAP_INTERVAL;
            m_tx_slot = (m_tx_slot + 1) % `STOCH_FRAME_SLOTS;
            m_cnt.a = step_count(m_cnt.a, ia, ib);
            m_cnt.b = step_count(m_cnt.b, sa, ib);
            m_cnt.c = step_count(m_cnt.c, sb, ib);
            if (m_rx_slot == 9) begin
                m_val.a = m_rx_a;
                m_val.b = m_rx_b;
            end else begin
                m_rx_a[m_rx_slot] = serial_a;
                m_rx_b[m_rx_slot] = serial_b;
            end
            m_rx_slot = (m_rx_slot + 1) % `STOCH_FRAME_SLOTS;
            m_lfsr = {m_lfsr[29:0], m_lfsr[27] ^ m_lfsr[30]};
        end
        if (m_rx_slot == 0) begin
            frame_a = next_a;  // Inputs change only at frame boundaries
            frame_b = next_b;
        end
        if (m_rx_slot == 9) begin
            junk = next_random();  // Receiver must ignore the dummy slot
            serial_a <= junk[31];
            serial_b <= junk[30];
        end else begin
            serial_a <= frame_a[m_rx_slot];
            serial_b <= frame_b[m_rx_slot];
        end
    end

    task automatic check_frame();
        frames++;
        if (dec !== m_frame) note_mismatch($sformatf("frame %0d/%0d/%0d, snapshot %0d/%0d/%0d",
            dec.a, dec.b, dec.c, m_frame.a, m_frame.b, m_frame.c));
        if (have_last && (mode == 1 || mode == 2) &&
            (dec.a < last_dec.a || dec.b < last_dec.b || dec.c < last_dec.c))
            note_mismatch("count fell with input B at zero");
        if (have_last && mode == 3 && dec.a > last_dec.a)
            note_mismatch("stage a rose with input A at zero");
        last_dec = dec;
        have_last = 1'b1;
    endtask

    // Outputs settle well before the falling edge
    always @(negedge clk) begin : check_outputs
        logic exp_c;
        exp_c = m_cnt.c > {m_lfsr[24:19], m_lfsr[14:12]};
        if (serial_out !== m_out)
            note_mismatch($sformatf("serial_out %b, expected %b", serial_out, m_out));
        if (stream_c !== exp_c)
            note_mismatch($sformatf("stream_c %b, expected %b", stream_c, exp_c));
        if (m_out_idx == 9) begin
            if (serial_out !== 3'b000) note_mismatch("dummy slot not zero");
        end else begin
            dec.a[m_out_idx] = serial_out.a;  // LSB first
            dec.b[m_out_idx] = serial_out.b;
            dec.c[m_out_idx] = serial_out.c;
            if (m_out_idx == 8) check_frame();
        end
    end

    task automatic run_test(input string name, input value_t a, input value_t b,
                            input int m, input int cycles);
        int err_start;
        @(negedge clk);
        #1;
        next_a = a;
        next_b = b;
        mode = 0;
        err_start = errors;
        repeat (SETTLE) @(negedge clk);
        #1;
        mode = m;
        have_last = 1'b0;
        repeat (cycles) @(negedge clk);
        #1;
        if (m == 2 && last_dec !== {3{9'd511}}) note_mismatch("counts did not saturate at 511");
        if (m == 3 && last_dec !== '0) note_mismatch("counts did not settle at 0");
        if (errors == err_start) tests_passed++;
        else tests_failed++;
        $display("Test %s a=%0d b=%0d: %s", name, a, b, (errors == err_start) ? "ok" : "bad");
    endtask

    initial begin : main
        rst_n <= 1'b1;
        repeat (3) @(posedge clk);
        rst_n <= 1'b0;
        run_test("reset", 9'd0, 9'd0, 3, 200);
        run_test("forward", random_value(), 9'd0, 1, 800);
        run_test("decrement", random_value(), random_value() | 9'd1, 0, 800);
        run_test("saturate_up", 9'd511, 9'd0, 2, 4000);
        run_test("saturate_down", 9'd0, 9'd511, 3, 4000);
        repeat (4) run_test("reload", random_value(), random_value(), 0, 200);
        $display("Summary: %0d tests ok, %0d bad, %0d frames, %0d mismatches, %0d assertion errors",
            tests_passed, tests_failed, frames, errors,
            stoch_integ_top_i.stoch_integ_assert_i.failures);
        if (errors == 0 && tests_failed == 0 &&
            stoch_integ_top_i.stoch_integ_assert_i.failures == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #((TOTAL_CYCLES + 1000) * PERIOD);
        $display("Timeout: tests still running after %0d cycles", TOTAL_CYCLES + 1000);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule
